// ==== tb/coproc_trace.txt ====
# instr rs0 rs1 id kill accept writeback loadstore data, all fields in hex
# data is the expected result_data, checked only when writeback is 1
000002db 00000000 00000000 1 0 1 1 0 deadbeef
0000002b 00001000 cafef00d 2 0 1 0 1 00000000
0000002b 00001004 12345678 3 0 1 0 1 00000000
000001b3 00000011 00000022 4 0 0 0 0 00000000
0000055b 00000000 00000000 5 0 1 1 0 deadbeef
0000038b 00001000 00000000 6 0 1 1 1 cafef00d
0000060b 00001004 00000000 7 0 1 1 1 12345678
0000002b 00002000 0badf00d 8 1 1 0 1 00000000
0000038b 00002000 00000000 9 0 1 1 1 ffffdfff
000002db 00000000 00000000 a 1 1 1 0 00000000
0000002b 00003000 a5a5a5a5 b 0 1 0 1 00000000
0000002b 00003004 5a5a5a5a c 0 1 0 1 00000000
00000e5b 00000000 00000000 d 0 1 1 0 deadbeef
0000038b 00003000 00000000 e 0 1 1 1 a5a5a5a5
0000060b 00003004 00000000 f 0 1 1 1 5a5a5a5a
0000007f 00000000 00000000 0 0 0 0 0 00000000
0000038b 00005000 00000000 1 1 1 1 1 00000000
0000002b 00004000 01020304 2 0 1 0 1 00000000
00000fdb 00000000 00000000 3 0 1 1 0 deadbeef
0000008b 00004000 00000000 4 0 1 1 1 01020304
0000008b 00000100 00000000 5 0 1 1 1 fffffeff

// ==== filelist.f ====
+incdir+src
src/xif_pkg.sv
src/coproc_pkg.sv
src/coproc_dispatch.sv
src/coproc_lane.sv
src/coproc_xif_merge.sv
src/coproc_top.sv
tb/tb_coproc.sv

// ==== Bender.yml ====
package:
  name: coproc

sources:
  - include_dirs:
      - src
    files:
      - src/xif_pkg.sv
      - src/coproc_pkg.sv
      - src/coproc_dispatch.sv
      - src/coproc_lane.sv
      - src/coproc_xif_merge.sv
      - src/coproc_top.sv
  - target: simulation
    files:
      - tb/tb_coproc.sv

// ==== tb/tb_coproc.sv ====
// reads tb/coproc_trace.txt relative to the run directory; a reused id waits until its result is back
`default_nettype none

module tb_coproc;

  localparam int NUM_IDS = 1 << $bits(xif_pkg::id_t);

  logic               clk_i;
  logic               rst_ni;
  logic               compressed_ready;
  logic               issue_valid;
  logic               issue_ready;
  xif_pkg::word_t     issue_instr;
  xif_pkg::word_t     issue_rs0;
  xif_pkg::word_t     issue_rs1;
  xif_pkg::id_t       issue_id;
  logic               issue_accept;
  logic               issue_writeback;
  logic               issue_loadstore;
  logic               commit_valid;
  xif_pkg::id_t       commit_id;
  logic               commit_kill;
  logic               mem_valid;
  logic               mem_ready;
  xif_pkg::id_t       mem_id;
  xif_pkg::word_t     mem_addr;
  logic               mem_we;
  xif_pkg::word_t     mem_wdata;
  xif_pkg::mem_size_t mem_size;
  logic               mem_result_valid;
  xif_pkg::id_t       mem_result_id;
  xif_pkg::word_t     mem_result_rdata;
  logic               result_valid;
  logic               result_ready;
  xif_pkg::id_t       result_id;
  xif_pkg::reg_idx_t  result_rd;
  logic               result_we;
  xif_pkg::word_t     result_data;

  // trace columns, one entry per instruction
  xif_pkg::word_t tr_instr[$];
  xif_pkg::word_t tr_rs0[$];
  xif_pkg::word_t tr_rs1[$];
  xif_pkg::id_t   tr_id[$];
  logic           tr_kill[$];
  logic           tr_acc[$];
  logic           tr_wb[$];
  logic           tr_ls[$];
  xif_pkg::word_t tr_data[$];

  // expectations per id in flight
  logic              res_pending[NUM_IDS];
  logic              exp_we[NUM_IDS];
  xif_pkg::reg_idx_t exp_rd[NUM_IDS];
  xif_pkg::word_t    exp_data[NUM_IDS];
  logic              exp_mem_we[NUM_IDS];
  xif_pkg::word_t    exp_mem_wdata[NUM_IDS];
  xif_pkg::id_t      exp_mem_id[xif_pkg::word_t]; // outstanding access by address

  xif_pkg::word_t mem_model[xif_pkg::word_t];
  xif_pkg::id_t   resp_id_q[$];
  xif_pkg::word_t resp_data_q[$];
  int             resp_due_q[$];

  int   cycle;
  int   cycle_limit;
  int   value_errs;
  int   other_errs;
  logic ready_low_seen;

  coproc_top i_dut (
    .clk_i, .rst_ni, .compressed_ready,
    .issue_valid, .issue_ready, .issue_instr, .issue_rs0, .issue_rs1, .issue_id,
    .issue_accept, .issue_writeback, .issue_loadstore,
    .commit_valid, .commit_id, .commit_kill,
    .mem_valid, .mem_ready, .mem_id, .mem_addr, .mem_we, .mem_wdata, .mem_size,
    .mem_result_valid, .mem_result_id, .mem_result_rdata,
    .result_valid, .result_ready, .result_id, .result_rd, .result_we, .result_data
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_word(input string name, input xif_pkg::word_t got,
                            input xif_pkg::word_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input xif_pkg::id_t got, input xif_pkg::id_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input xif_pkg::reg_idx_t got,
                           input xif_pkg::reg_idx_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input xif_pkg::mem_size_t got,
                            input xif_pkg::mem_size_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic logic any_pending();
    for (int i = 0; i < NUM_IDS; i++) begin
      if (res_pending[i]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic finish_run();
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // issue one trace line, commit or kill it, check the issue response
  task automatic issue_one(input int n);
    xif_pkg::id_t id;
    int           delay;
    logic         live;
    id    = tr_id[n];
    live  = tr_acc[n] && !tr_kill[n];
    delay = tr_kill[n] ? 0 : int'($urandom % 4);
    while (res_pending[id] || (tr_ls[n] && exp_mem_id.exists(tr_rs0[n]))) begin
      @(negedge clk_i);
    end
    while (!issue_ready) begin
      ready_low_seen = 1'b1; // both lanes busy
      @(negedge clk_i);
    end
    if (live) begin
      res_pending[id] = 1'b1;
      exp_we[id]      = tr_wb[n];
      exp_rd[id]      = tr_instr[n][11:7];
      exp_data[id]    = tr_data[n];
      if (tr_ls[n]) begin
        exp_mem_id[tr_rs0[n]] = id;
        exp_mem_we[id]        = !tr_wb[n]; // store writes nothing back
        exp_mem_wdata[id]     = tr_rs1[n];
      end
    end
    @(posedge clk_i);
    issue_valid <= 1'b1;
    issue_instr <= tr_instr[n];
    issue_rs0   <= tr_rs0[n];
    issue_rs1   <= tr_rs1[n];
    issue_id    <= id;
    if (delay == 0) begin
      commit_valid <= 1'b1;
      commit_id    <= id;
      commit_kill  <= tr_kill[n];
    end
    @(negedge clk_i);
    check_flag("issue_accept", issue_accept, tr_acc[n]);
    check_flag("issue_writeback", issue_writeback, tr_wb[n]);
    check_flag("issue_loadstore", issue_loadstore, tr_ls[n]);
    @(posedge clk_i); // handshake edge
    issue_valid  <= 1'b0;
    commit_valid <= 1'b0;
    if (delay > 0) begin
      repeat (delay - 1) @(posedge clk_i);
      commit_valid <= 1'b1;
      commit_id    <= id;
      commit_kill  <= 1'b0;
      @(posedge clk_i);
      commit_valid <= 1'b0;
    end
    @(negedge clk_i);
  endtask

  initial begin : main
    int             fd;
    string          line;
    xif_pkg::word_t f_instr;
    xif_pkg::word_t f_rs0;
    xif_pkg::word_t f_rs1;
    xif_pkg::word_t f_data;
    xif_pkg::id_t   f_id;
    logic           f_kill;
    logic           f_acc;
    logic           f_wb;
    logic           f_ls;
    void'($urandom(32'h2c38));
    rst_ni           = 1'b0;
    issue_valid      = 1'b0;
    issue_instr      = '0;
    issue_rs0        = '0;
    issue_rs1        = '0;
    issue_id         = '0;
    commit_valid     = 1'b0;
    commit_id        = '0;
    commit_kill      = 1'b0;
    mem_ready        = 1'b0;
    mem_result_valid = 1'b0;
    mem_result_id    = '0;
    mem_result_rdata = '0;
    result_ready     = 1'b0;
    value_errs       = 0;
    other_errs       = 0;
    ready_low_seen   = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) begin
      res_pending[i] = 1'b0;
    end
    fd = $fopen("tb/coproc_trace.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Cannot open trace file tb/coproc_trace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h %h %h %h %h %h %h", f_instr, f_rs0, f_rs1, f_id,
                      f_kill, f_acc, f_wb, f_ls, f_data) == 9) begin
            tr_instr.push_back(f_instr);
            tr_rs0.push_back(f_rs0);
            tr_rs1.push_back(f_rs1);
            tr_id.push_back(f_id);
            tr_kill.push_back(f_kill);
            tr_acc.push_back(f_acc);
            tr_wb.push_back(f_wb);
            tr_ls.push_back(f_ls);
            tr_data.push_back(f_data);
          end else begin
            other_errs++;
            $display("Malformed trace line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 60 * tr_instr.size() + 200;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("issue_ready", issue_ready, 1'b1); // all lanes idle
    check_flag("mem_valid", mem_valid, 1'b0);
    check_flag("result_valid", result_valid, 1'b0);
    check_flag("compressed_ready", compressed_ready, 1'b0);
    foreach (tr_instr[i]) begin
      issue_one(i);
    end
    while (any_pending()) begin
      @(negedge clk_i);
    end
    repeat (20) @(negedge clk_i); // room for stray results of killed ids
    if (!ready_low_seen) begin
      other_errs++;
      $display("issue_ready never dropped while both lanes were busy");
    end
    finish_run();
  end

  // memory model, result back-pressure and result checks
  always @(posedge clk_i) begin : monitor
    xif_pkg::id_t   owner;
    xif_pkg::word_t rdata;
    if (!rst_ni) begin
      cycle             = 0;
      mem_ready        <= 1'b0;
      result_ready     <= 1'b0;
      mem_result_valid <= 1'b0;
    end else begin
      cycle++;
      mem_ready        <= ($urandom % 4) != 0;
      result_ready     <= ($urandom % 3) != 0;
      mem_result_valid <= 1'b0;
      if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle) begin
        mem_result_valid <= 1'b1;
        mem_result_id    <= resp_id_q.pop_front();
        mem_result_rdata <= resp_data_q.pop_front();
        void'(resp_due_q.pop_front());
      end
      if (mem_valid && mem_ready) begin
        if (!exp_mem_id.exists(mem_addr)) begin
          other_errs++;
          $display("Unexpected memory request to address %h", mem_addr);
        end else begin
          owner = exp_mem_id[mem_addr];
          exp_mem_id.delete(mem_addr);
          check_id("mem_id", mem_id, owner);
          check_flag("mem_we", mem_we, exp_mem_we[owner]);
          check_size("mem_size", mem_size, 3'd2); // log2 of four bytes
          if (exp_mem_we[owner]) begin
            check_word("mem_wdata", mem_wdata, exp_mem_wdata[owner]);
          end
        end
        if (mem_we) begin
          mem_model[mem_addr] = mem_wdata;
          rdata               = mem_wdata;
        end else begin
          rdata = mem_model.exists(mem_addr) ? mem_model[mem_addr] : ~mem_addr; // fill
        end
        resp_id_q.push_back(mem_id);
        resp_data_q.push_back(rdata);
        resp_due_q.push_back(cycle + 1 + int'($urandom % 3));
      end
      if (result_valid && result_ready) begin
        if (!res_pending[result_id]) begin
          other_errs++;
          $display("Unexpected result for id %0d", result_id);
        end else begin
          res_pending[result_id] = 1'b0;
          check_flag("result_we", result_we, exp_we[result_id]);
          if (exp_we[result_id]) begin
            check_reg("result_rd", result_rd, exp_rd[result_id]);
            check_word("result_data", result_data, exp_data[result_id]);
          end
        end
      end
    end
  end

  initial begin : watchdog
    @(posedge rst_ni);
    for (int c = 0; c < cycle_limit; c++) begin
      @(posedge clk_i);
    end
    other_errs++;
    $display("Timeout after %0d cycles", cycle_limit);
    for (int i = 0; i < NUM_IDS; i++) begin
      if (res_pending[i]) begin
        $display("Result for id %0d never arrived", i);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== src/coproc_top.sv ====
// no compressed instructions, exceptions, dual ports or ecs writes; mem accesses are words
`default_nettype none
`include "coproc_defines.svh"

module coproc_top (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  output logic                    compressed_ready,
  input  wire                     issue_valid,
  output logic                    issue_ready,
  input  wire  xif_pkg::word_t    issue_instr,
  input  wire  xif_pkg::word_t    issue_rs0,
  input  wire  xif_pkg::word_t    issue_rs1,
  input  wire  xif_pkg::id_t      issue_id,
  output logic                    issue_accept,
  output logic                    issue_writeback,
  output logic                    issue_loadstore,
  input  wire                     commit_valid,
  input  wire  xif_pkg::id_t      commit_id,
  input  wire                     commit_kill,
  output logic                    mem_valid,
  input  wire                     mem_ready,
  output xif_pkg::id_t            mem_id,
  output xif_pkg::word_t          mem_addr,
  output logic                    mem_we,
  output xif_pkg::word_t          mem_wdata,
  output xif_pkg::mem_size_t      mem_size,
  input  wire                     mem_result_valid,
  input  wire  xif_pkg::id_t      mem_result_id,
  input  wire  xif_pkg::word_t    mem_result_rdata,
  output logic                    result_valid,
  input  wire                     result_ready,
  output xif_pkg::id_t            result_id,
  output xif_pkg::reg_idx_t       result_rd,
  output logic                    result_we,
  output xif_pkg::word_t          result_data
);

  localparam int N = `COPROC_NUM_LANES;

  // dispatcher broadcast
  logic [N-1:0]         lane_busy;
  logic [N-1:0]         lane_start;
  coproc_pkg::lane_op_e start_op;
  xif_pkg::id_t         start_id;
  xif_pkg::reg_idx_t    start_rd;
  xif_pkg::word_t       start_addr;
  xif_pkg::word_t       start_wdata;

  // lane side of the merge unit
  logic [N-1:0]              lane_mem_valid;
  logic [N-1:0]              lane_mem_we;
  logic [N-1:0]              lane_mem_grant;
  xif_pkg::word_t [N-1:0]    lane_mem_addr;
  xif_pkg::word_t [N-1:0]    lane_mem_wdata;
  xif_pkg::id_t [N-1:0]      lane_id;
  logic [N-1:0]              lane_res_valid;
  logic [N-1:0]              lane_res_we;
  logic [N-1:0]              lane_res_grant;
  xif_pkg::reg_idx_t [N-1:0] lane_res_rd;
  xif_pkg::word_t [N-1:0]    lane_res_data;
  logic                      resp_valid;
  xif_pkg::id_t              resp_id;
  xif_pkg::word_t            resp_rdata;

  assign compressed_ready = 1'b0;

  coproc_dispatch i_dispatch (
    .clk_i, .rst_ni,
    .issue_valid, .issue_instr, .issue_rs0, .issue_rs1, .issue_id,
    .lane_busy,
    .issue_ready, .issue_accept, .issue_writeback, .issue_loadstore,
    .lane_start,
    .lane_op    (start_op),
    .lane_id    (start_id),
    .lane_rd    (start_rd),
    .lane_addr  (start_addr),
    .lane_wdata (start_wdata)
  );

  for (genvar g = 0; g < N; g++) begin : g_lane
    coproc_lane i_lane (
      .clk_i, .rst_ni,
      .start            (lane_start[g]),
      .op               (start_op),
      .id_in            (start_id),
      .rd_in            (start_rd),
      .addr_in          (start_addr),
      .wdata_in         (start_wdata),
      .commit_valid, .commit_id, .commit_kill,
      .mem_grant        (lane_mem_grant[g]),
      .mem_result_valid (resp_valid),
      .mem_result_id    (resp_id),
      .mem_result_rdata (resp_rdata),
      .res_grant        (lane_res_grant[g]),
      .busy             (lane_busy[g]),
      .mem_req_valid    (lane_mem_valid[g]),
      .mem_req_we       (lane_mem_we[g]),
      .mem_req_addr     (lane_mem_addr[g]),
      .mem_req_wdata    (lane_mem_wdata[g]),
      .lane_id          (lane_id[g]),
      .res_valid        (lane_res_valid[g]),
      .res_rd           (lane_res_rd[g]),
      .res_we           (lane_res_we[g]),
      .res_data         (lane_res_data[g])
    );
  end

  coproc_xif_merge i_merge (
    .clk_i, .rst_ni,
    .lane_mem_valid, .lane_mem_we, .lane_mem_addr, .lane_mem_wdata, .lane_id,
    .lane_res_valid, .lane_res_rd, .lane_res_we, .lane_res_data,
    .mem_ready, .mem_result_valid, .mem_result_id, .mem_result_rdata, .result_ready,
    .lane_mem_grant, .lane_res_grant,
    .mem_valid, .mem_id, .mem_addr, .mem_we, .mem_wdata, .mem_size,
    .result_valid, .result_id, .result_rd, .result_we, .result_data,
    .resp_valid, .resp_id, .resp_rdata
  );

endmodule

`default_nettype wire

// ==== src/coproc_xif_merge.sv ====
// fixed priority, lowest lane first on both channels; a busy lane 0 can starve the others
`default_nettype none
`include "coproc_defines.svh"

module coproc_xif_merge (
  input  wire                                           clk_i,
  input  wire                                           rst_ni,
  input  wire  [`COPROC_NUM_LANES-1:0]                  lane_mem_valid,
  input  wire  [`COPROC_NUM_LANES-1:0]                  lane_mem_we,
  input  wire  xif_pkg::word_t [`COPROC_NUM_LANES-1:0]  lane_mem_addr,
  input  wire  xif_pkg::word_t [`COPROC_NUM_LANES-1:0]  lane_mem_wdata,
  input  wire  xif_pkg::id_t [`COPROC_NUM_LANES-1:0]    lane_id,
  input  wire  [`COPROC_NUM_LANES-1:0]                  lane_res_valid,
  input  wire  xif_pkg::reg_idx_t [`COPROC_NUM_LANES-1:0] lane_res_rd,
  input  wire  [`COPROC_NUM_LANES-1:0]                  lane_res_we,
  input  wire  xif_pkg::word_t [`COPROC_NUM_LANES-1:0]  lane_res_data,
  input  wire                                           mem_ready,
  input  wire                                           mem_result_valid,
  input  wire  xif_pkg::id_t                            mem_result_id,
  input  wire  xif_pkg::word_t                          mem_result_rdata,
  input  wire                                           result_ready,
  output logic [`COPROC_NUM_LANES-1:0]                  lane_mem_grant,
  output logic [`COPROC_NUM_LANES-1:0]                  lane_res_grant,
  output logic                                          mem_valid,
  output xif_pkg::id_t                                  mem_id,
  output xif_pkg::word_t                                mem_addr,
  output logic                                          mem_we,
  output xif_pkg::word_t                                mem_wdata,
  output xif_pkg::mem_size_t                            mem_size,
  output logic                                          result_valid,
  output xif_pkg::id_t                                  result_id,
  output xif_pkg::reg_idx_t                             result_rd,
  output logic                                          result_we,
  output xif_pkg::word_t                                result_data,
  output logic                                          resp_valid,
  output xif_pkg::id_t                                  resp_id,
  output xif_pkg::word_t                                resp_rdata
);

  coproc_pkg::lane_idx_t mem_sel;
  coproc_pkg::lane_idx_t res_sel;
  logic                  mem_load; // output stage empty or handing off
  logic                  res_load;

  assign mem_sel  = coproc_pkg::first_set(lane_mem_valid);
  assign res_sel  = coproc_pkg::first_set(lane_res_valid);
  assign mem_load = !mem_valid || mem_ready;
  assign res_load = !result_valid || result_ready;

  // grant pulse makes the lane drop its request next cycle
  always_comb begin
    lane_mem_grant          = '0;
    lane_res_grant          = '0;
    lane_mem_grant[mem_sel] = mem_load && |lane_mem_valid;
    lane_res_grant[res_sel] = res_load && |lane_res_valid;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_valid    <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      if (mem_load) begin
        mem_valid <= |lane_mem_valid;
      end
      if (res_load) begin
        result_valid <= |lane_res_valid;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|lane_mem_grant) begin
      mem_id    <= lane_id[mem_sel];
      mem_addr  <= lane_mem_addr[mem_sel];
      mem_we    <= lane_mem_we[mem_sel];
      mem_wdata <= lane_mem_wdata[mem_sel];
    end
    if (|lane_res_grant) begin
      result_id   <= lane_id[res_sel];
      result_rd   <= lane_res_rd[res_sel];
      result_we   <= lane_res_we[res_sel];
      result_data <= lane_res_data[res_sel];
    end
  end

  assign mem_size = xif_pkg::MEM_SIZE_WORD;

  // every lane sees the response, the id picks the owner
  assign resp_valid = mem_result_valid;
  assign resp_id    = mem_result_id;
  assign resp_rdata = mem_result_rdata;

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(lane_mem_grant) && $onehot0(lane_res_grant));

  // a stalled request must not change under the memory
  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_id));

endmodule

`default_nettype wire

// ==== src/coproc_lane.sv ====
// one instruction at a time; ids are unique among lanes in flight and kills precede commit
`default_nettype none
`include "coproc_defines.svh"

module coproc_lane (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  start,
  input  wire  coproc_pkg::lane_op_e op,
  input  wire  xif_pkg::id_t   id_in,
  input  wire  xif_pkg::reg_idx_t rd_in,
  input  wire  xif_pkg::word_t addr_in,
  input  wire  xif_pkg::word_t wdata_in,
  input  wire                  commit_valid,
  input  wire  xif_pkg::id_t   commit_id,
  input  wire                  commit_kill,
  input  wire                  mem_grant,
  input  wire                  mem_result_valid,
  input  wire  xif_pkg::id_t   mem_result_id,
  input  wire  xif_pkg::word_t mem_result_rdata,
  input  wire                  res_grant,
  output logic                 busy,
  output logic                 mem_req_valid,
  output logic                 mem_req_we,
  output xif_pkg::word_t       mem_req_addr,
  output xif_pkg::word_t       mem_req_wdata,
  output xif_pkg::id_t         lane_id,
  output logic                 res_valid,
  output xif_pkg::reg_idx_t    res_rd,
  output logic                 res_we,
  output xif_pkg::word_t       res_data
);

  coproc_pkg::lane_state_e state_q, state_d;
  coproc_pkg::lane_op_e    op_q;
  xif_pkg::id_t            id_q;
  xif_pkg::reg_idx_t       rd_q;
  xif_pkg::word_t          addr_q;
  xif_pkg::word_t          data_q;    // store data, later load data or magic
  logic                    commit_q;  // sticky commit
  logic                    commit_hit;
  logic                    kill_hit;
  logic                    committed;
  logic                    resp_hit;

  // on the start cycle our id is still on the input
  assign commit_hit = commit_valid && (commit_id == (start ? id_in : id_q));
  assign kill_hit   = commit_hit && commit_kill;
  assign committed  = commit_q || (commit_hit && !commit_kill);
  assign resp_hit   = mem_result_valid && (mem_result_id == id_q);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      coproc_pkg::IDLE: begin
        if (start) begin
          state_d = coproc_pkg::WAIT_COMMIT;
        end
      end
      coproc_pkg::WAIT_COMMIT: begin
        if (committed) begin
          state_d = (op_q == coproc_pkg::OP_TEST) ? coproc_pkg::RETIRE : coproc_pkg::MEM_REQ;
        end
      end
      coproc_pkg::MEM_REQ: begin
        if (mem_grant) begin
          state_d = coproc_pkg::MEM_RESP;
        end
      end
      coproc_pkg::MEM_RESP: begin
        if (resp_hit) begin
          state_d = coproc_pkg::RETIRE;
        end
      end
      coproc_pkg::RETIRE: begin
        if (res_grant) begin
          state_d = coproc_pkg::IDLE;
        end
      end
      default: state_d = coproc_pkg::IDLE;
    endcase
    // killed before retire, drop everything
    if (kill_hit && state_q != coproc_pkg::RETIRE) begin
      state_d = coproc_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= coproc_pkg::IDLE;
      commit_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d == coproc_pkg::IDLE) begin
        commit_q <= 1'b0;
      end else if (commit_hit && !commit_kill) begin
        commit_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      op_q   <= op;
      id_q   <= id_in;
      rd_q   <= rd_in;
      addr_q <= addr_in;
      data_q <= (op == coproc_pkg::OP_TEST) ? coproc_pkg::TEST_MAGIC : wdata_in;
    end else if (state_q == coproc_pkg::MEM_RESP && resp_hit && op_q == coproc_pkg::OP_LOAD) begin
      data_q <= mem_result_rdata;
    end
  end

  assign busy          = (state_q != coproc_pkg::IDLE);
  assign mem_req_valid = (state_q == coproc_pkg::MEM_REQ);
  assign mem_req_we    = (op_q == coproc_pkg::OP_STORE);
  assign mem_req_addr  = addr_q;
  assign mem_req_wdata = data_q;
  assign lane_id       = id_q;
  assign res_valid     = (state_q == coproc_pkg::RETIRE);
  assign res_rd        = rd_q;
  assign res_we        = (op_q != coproc_pkg::OP_STORE); // stores write nothing back
  assign res_data      = data_q;

  // the merge unit may stall the result for many cycles
  a_res_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid && !res_grant |=> res_valid);

  a_state_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(state_q));

endmodule

`default_nettype wire

// ==== src/coproc_dispatch.sv ====
// one issue per cycle; accept, writeback and loadstore come from the major opcode alone
`default_nettype none
`include "coproc_defines.svh"

module coproc_dispatch (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          issue_valid,
  input  wire  xif_pkg::word_t         issue_instr,
  input  wire  xif_pkg::word_t         issue_rs0,
  input  wire  xif_pkg::word_t         issue_rs1,
  input  wire  xif_pkg::id_t           issue_id,
  input  wire  [`COPROC_NUM_LANES-1:0] lane_busy,
  output logic                         issue_ready,
  output logic                         issue_accept,
  output logic                         issue_writeback,
  output logic                         issue_loadstore,
  output logic [`COPROC_NUM_LANES-1:0] lane_start,
  output coproc_pkg::lane_op_e         lane_op,
  output xif_pkg::id_t                 lane_id,
  output xif_pkg::reg_idx_t            lane_rd,
  output xif_pkg::word_t               lane_addr,
  output xif_pkg::word_t               lane_wdata
);

  coproc_pkg::opcode_e   opcode;
  coproc_pkg::lane_idx_t free_idx; // lowest idle lane
  logic                  fire;

  assign opcode = coproc_pkg::opcode_e'(issue_instr[6:0]);

  always_comb begin
    issue_accept    = 1'b1;
    issue_writeback = 1'b0;
    issue_loadstore = 1'b0;
    lane_op         = coproc_pkg::OP_TEST;
    case (opcode)
      coproc_pkg::OPCODE_TEST: issue_writeback = 1'b1;
      coproc_pkg::OPCODE_RMLD: begin
        lane_op         = coproc_pkg::OP_LOAD;
        issue_writeback = 1'b1;
        issue_loadstore = 1'b1;
      end
      coproc_pkg::OPCODE_RMST: begin
        lane_op         = coproc_pkg::OP_STORE;
        issue_loadstore = 1'b1;
      end
      default: issue_accept = 1'b0; // not ours, rejected
    endcase
  end

  assign issue_ready = ~&lane_busy;
  assign free_idx    = coproc_pkg::first_set(~lane_busy);
  assign fire        = issue_valid && issue_ready && issue_accept;

  always_comb begin
    lane_start           = '0;
    lane_start[free_idx] = fire;
  end

  // operand broadcast, only the started lane latches it
  assign lane_id    = issue_id;
  assign lane_rd    = issue_instr[11:7];
  assign lane_addr  = issue_rs0;
  assign lane_wdata = issue_rs1;

  // the busy flags come back from the lanes
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(lane_start) && ((lane_start & lane_busy) == '0));

endmodule

`default_nettype wire

// ==== src/coproc_pkg.sv ====
// opcodes use the custom-0/1/2 major slots; funct fields are never decoded
`default_nettype none
`include "coproc_defines.svh"

package coproc_pkg;

  typedef enum logic [6:0] {
    OPCODE_RMLD = 7'b000_1011, // custom-0
    OPCODE_RMST = 7'b010_1011, // custom-1
    OPCODE_TEST = 7'b101_1011  // custom-2
  } opcode_e;

  typedef enum logic [1:0] {
    OP_TEST  = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } lane_op_e;

  typedef enum logic [4:0] {
    IDLE        = 5'b00001,
    WAIT_COMMIT = 5'b00010,
    MEM_REQ     = 5'b00100,
    MEM_RESP    = 5'b01000,
    RETIRE      = 5'b10000
  } lane_state_e;

  localparam xif_pkg::word_t TEST_MAGIC = 32'hDEADBEEF;

  typedef logic [`COPROC_LANE_W-1:0] lane_idx_t;

  // lowest set bit of a lane mask, zero for an empty mask
  function automatic lane_idx_t first_set(input logic [`COPROC_NUM_LANES-1:0] mask);
    lane_idx_t idx;
    idx = '0;
    for (int i = `COPROC_NUM_LANES - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = lane_idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

// ==== src/xif_pkg.sv ====
// field types of the eXtension interface; word accesses only, no byte enables or attributes
`default_nettype none
`include "coproc_defines.svh"

package xif_pkg;

  typedef logic [`COPROC_ID_W-1:0]  id_t;      // offloaded instruction id
  typedef logic [`COPROC_XLEN-1:0]  word_t;    // operand, address or data
  typedef logic [`COPROC_REG_W-1:0] reg_idx_t; // destination register
  typedef logic [2:0]               mem_size_t;

  // log2 of the byte count, as on the mem channel
  localparam mem_size_t MEM_SIZE_WORD = 3'd2;

endpackage

`default_nettype wire

// ==== src/coproc_defines.svh ====
// global sizes for every module; the lane index never drops below one bit
`ifndef COPROC_DEFINES_SVH
`define COPROC_DEFINES_SVH

`define COPROC_NUM_LANES 2 // instructions in flight at once
`define COPROC_ID_W      4 // xif instruction id
`define COPROC_XLEN      32 // operand, address and data width
`define COPROC_REG_W     5 // rd field of the instruction

// lane index width
`define COPROC_LANE_W ((`COPROC_NUM_LANES > 1) ? $clog2(`COPROC_NUM_LANES) : 1)

`endif
